// File: source/exu_pkg.sv
package exu_pkg;

  localparam int xlen       = 32;
  localparam int dmem_words = 256;
  localparam int dmem_aw    = $clog2(dmem_words);

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    csr_none,
    csr_rw,
    csr_rs,
    csr_rc,
    csr_ecall,
    csr_mret,
    csr_ebreak
  } csr_op_e;

  // access size, same encoding as funct3[1:0]
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  localparam int mstatus_mie_idx  = 3;
  localparam int mstatus_mpie_idx = 7;

  localparam logic [xlen-1:0] mcause_ecall_m = 11;

endpackage

// File: source/exu_ctrl_if.sv
`timescale 1ns/1ps

interface exu_ctrl_if;
  import exu_pkg::*;

  logic            valid;
  opcode_e         opcode;
  alu_op_e         alu_op;
  csr_op_e         csr_op;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] pc;
  logic [11:0]     csr_addr;
  logic [4:0]      rd;
  logic            rd_we;
  logic            mem_read;
  logic            mem_write;
  logic [1:0]      mem_size;
  logic            mem_unsigned;
  logic            illegal;

  modport source (
    output valid, opcode, alu_op, csr_op, op_a, op_b, rs1_data, rs2_data, imm, pc,
           csr_addr, rd, rd_we, mem_read, mem_write, mem_size, mem_unsigned, illegal
  );

  modport sink (
    input valid, opcode, alu_op, csr_op, op_a, op_b, rs1_data, rs2_data, imm, pc,
          csr_addr, rd, rd_we, mem_read, mem_write, mem_size, mem_unsigned, illegal
  );

endinterface

// File: source/exu_result_if.sv
`timescale 1ns/1ps

interface exu_result_if;
  import exu_pkg::*;

  logic            valid;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] store_data;
  logic            mem_read;
  logic            mem_write;
  logic [1:0]      mem_size;
  logic            mem_unsigned;
  logic [4:0]      rd;
  logic            rd_we;
  logic [xlen-1:0] rd_data_pre;
  logic [xlen-1:0] next_pc;
  logic            ebreak;
  logic            illegal;

  modport source (
    output valid, alu_result, store_data, mem_read, mem_write, mem_size, mem_unsigned,
           rd, rd_we, rd_data_pre, next_pc, ebreak, illegal
  );

  modport sink (
    input valid, alu_result, store_data, mem_read, mem_write, mem_size, mem_unsigned,
          rd, rd_we, rd_data_pre, next_pc, ebreak, illegal
  );

endinterface

// File: source/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid_i,
  input  logic [31:0]              inst_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  input  logic [exu_pkg::xlen-1:0] rs1_data_i,
  input  logic [exu_pkg::xlen-1:0] rs2_data_i,
  exu_ctrl_if.source               ctrl
);
  import exu_pkg::*;

  logic [2:0]      funct3;
  logic            funct7_alt;
  logic            funct7_ok;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  opcode_e         opcode;
  alu_op_e         alu_op;
  csr_op_e         csr_op;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] imm;
  logic            rd_we;
  logic            mem_read;
  logic            mem_write;
  logic [1:0]      mem_size;
  logic            mem_unsigned;
  logic            illegal;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? alu_sub : alu_add;
      3'd1:    return alu_sll;
      3'd2:    return alu_slt;
      3'd3:    return alu_sltu;
      3'd4:    return alu_xor;
      3'd5:    return alt ? alu_sra : alu_srl;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign funct3     = inst_i[14:12];
  assign funct7_alt = inst_i[30];
  // only 0000000 and 0100000 are defined
  assign funct7_ok  = (inst_i[31:25] & 7'b1011111) == 7'b0;

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    opcode       = opcode_e'(inst_i[6:0]);
    alu_op       = alu_add;
    csr_op       = csr_none;
    op_a         = rs1_data_i;
    op_b         = rs2_data_i;
    imm          = imm_i;
    rd_we        = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    mem_size     = funct3[1:0];
    mem_unsigned = funct3[2];
    illegal      = 1'b0;
    case (opcode)
      opc_lui: begin
        op_a  = '0;
        op_b  = imm_u;
        imm   = imm_u;
        rd_we = 1'b1;
      end
      opc_auipc: begin
        op_a  = pc_i;
        op_b  = imm_u;
        imm   = imm_u;
        rd_we = 1'b1;
      end
      opc_jal: begin
        imm   = imm_j;
        rd_we = 1'b1;
      end
      opc_jalr: begin
        rd_we   = 1'b1;
        illegal = funct3 != 3'd0;
      end
      opc_branch: begin
        imm          = imm_b;
        // odd funct3 inverts the compare, carried in mem_unsigned
        mem_unsigned = funct3[0];
        case (funct3[2:1])
          2'b00:   alu_op = alu_sub;
          2'b10:   alu_op = alu_slt;
          2'b11:   alu_op = alu_sltu;
          default: illegal = 1'b1;
        endcase
      end
      opc_load: begin
        op_b     = imm_i;
        mem_read = 1'b1;
        rd_we    = 1'b1;
        illegal  = funct3[1:0] == 2'b11 || funct3[2:1] == 2'b11;
      end
      opc_store: begin
        op_b      = imm_s;
        imm       = imm_s;
        mem_write = 1'b1;
        illegal   = funct3[2] || funct3[1:0] == 2'b11;
      end
      opc_op_imm: begin
        op_b    = imm_i;
        rd_we   = 1'b1;
        alu_op  = alu_from_f3(funct3, funct7_alt && funct3 == 3'd5);
        illegal = (funct3 == 3'd1 && inst_i[31:25] != 7'b0) ||
                  (funct3 == 3'd5 && !funct7_ok);
      end
      opc_op: begin
        rd_we   = 1'b1;
        alu_op  = alu_from_f3(funct3, funct7_alt);
        illegal = !funct7_ok || (funct7_alt && funct3 != 3'd0 && funct3 != 3'd5);
      end
      opc_system: begin
        // immediate forms take the zero-extended uimm
        op_a  = funct3[2] ? xlen'(inst_i[19:15]) : rs1_data_i;
        rd_we = 1'b1;
        case (funct3)
          3'd0: begin
            rd_we = 1'b0;
            case (inst_i[31:7])
              25'h0:            csr_op = csr_ecall;
              {12'h001, 13'h0}: csr_op = csr_ebreak;
              {12'h302, 13'h0}: csr_op = csr_mret;
              default:          illegal = 1'b1;
            endcase
          end
          3'd1, 3'd5: csr_op = csr_rw;
          3'd2, 3'd6: csr_op = csr_rs;
          3'd3, 3'd7: csr_op = csr_rc;
          default:    illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      rd_we     = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      csr_op    = csr_none;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.valid <= 1'b0;
    end else begin
      ctrl.valid <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    ctrl.opcode       <= opcode;
    ctrl.alu_op       <= alu_op;
    ctrl.csr_op       <= csr_op;
    ctrl.op_a         <= op_a;
    ctrl.op_b         <= op_b;
    ctrl.rs1_data     <= rs1_data_i;
    ctrl.rs2_data     <= rs2_data_i;
    ctrl.imm          <= imm;
    ctrl.pc           <= pc_i;
    ctrl.csr_addr     <= inst_i[31:20];
    ctrl.rd           <= inst_i[11:7];
    ctrl.rd_we        <= rd_we;
    ctrl.mem_read     <= mem_read;
    ctrl.mem_write    <= mem_write;
    ctrl.mem_size     <= mem_size;
    ctrl.mem_unsigned <= mem_unsigned;
    ctrl.illegal      <= illegal;
  end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [exu_pkg::xlen-1:0] a_i,
  input  logic [exu_pkg::xlen-1:0] b_i,
  input  exu_pkg::alu_op_e         op_i,
  output logic [exu_pkg::xlen-1:0] result_o
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      alu_add:  result_o = a_i + b_i;
      alu_sub:  result_o = a_i - b_i;
      alu_sll:  result_o = a_i << shamt;
      alu_slt:  result_o = xlen'($signed(a_i) < $signed(b_i));
      alu_sltu: result_o = xlen'(a_i < b_i);
      alu_xor:  result_o = a_i ^ b_i;
      alu_srl:  result_o = a_i >> shamt;
      alu_sra:  result_o = $signed(a_i) >>> shamt;
      alu_or:   result_o = a_i | b_i;
      alu_and:  result_o = a_i & b_i;
      default:  result_o = '0;
    endcase
  end

endmodule

// File: source/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [11:0]              addr_i,
  input  logic                     we_i,
  input  logic [exu_pkg::xlen-1:0] wdata_i,
  input  logic                     ecall_i,
  input  logic                     mret_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  output logic [exu_pkg::xlen-1:0] rdata_o,
  output logic [exu_pkg::xlen-1:0] mtvec_o,
  output logic [exu_pkg::xlen-1:0] mepc_o
);
  import exu_pkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (ecall_i) begin
      mepc   <= pc_i;
      mcause <= mcause_ecall_m;
    end else if (mret_i) begin
      mstatus[mstatus_mie_idx]  <= mstatus[mstatus_mpie_idx];
      mstatus[mstatus_mpie_idx] <= 1'b1;
    end else if (we_i) begin
      case (addr_i)
        csr_mstatus: mstatus <= wdata_i;
        csr_mtvec:   mtvec   <= wdata_i;
        csr_mepc:    mepc    <= wdata_i;
        csr_mcause:  mcause  <= wdata_i;
        default: begin
        end
      endcase
    end
  end

  // unimplemented addresses read as zero
  always_comb begin
    case (addr_i)
      csr_mstatus: rdata_o = mstatus;
      csr_mtvec:   rdata_o = mtvec;
      csr_mepc:    rdata_o = mepc;
      csr_mcause:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

// File: source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic         clk,
  input  logic         rst,
  exu_ctrl_if.sink     ctrl,
  exu_result_if.source res
);
  import exu_pkg::*;

  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] csr_wdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] rd_data_pre;
  logic            csr_we;
  logic            ecall;
  logic            mret;
  logic            branch_taken;

  alu u_alu (
    .a_i      (ctrl.op_a),
    .b_i      (ctrl.op_b),
    .op_i     (ctrl.alu_op),
    .result_o (alu_result)
  );

  assign csr_we = ctrl.valid && (ctrl.csr_op inside {csr_rw, csr_rs, csr_rc});
  assign ecall  = ctrl.valid && ctrl.csr_op == csr_ecall;
  assign mret   = ctrl.valid && ctrl.csr_op == csr_mret;

  always_comb begin
    case (ctrl.csr_op)
      csr_rs:  csr_wdata = csr_rdata | ctrl.op_a;
      csr_rc:  csr_wdata = csr_rdata & ~ctrl.op_a;
      default: csr_wdata = ctrl.op_a;
    endcase
  end

  csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (ctrl.csr_addr),
    .we_i    (csr_we),
    .wdata_i (csr_wdata),
    .ecall_i (ecall),
    .mret_i  (mret),
    .pc_i    (ctrl.pc),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  assign pc_plus4  = ctrl.pc + xlen'(4);
  assign pc_target = ctrl.pc + ctrl.imm;
  // sub tests equality, slt and sltu give a single bit
  assign branch_taken = ((ctrl.alu_op == alu_sub) ? alu_result == '0 : alu_result[0]) ^
                        ctrl.mem_unsigned;

  always_comb begin
    next_pc     = pc_plus4;
    rd_data_pre = alu_result;
    case (ctrl.opcode)
      opc_jal: begin
        next_pc     = pc_target;
        rd_data_pre = pc_plus4;
      end
      opc_jalr: begin
        next_pc     = (ctrl.rs1_data + ctrl.imm) & ~xlen'(1);
        rd_data_pre = pc_plus4;
      end
      opc_branch: begin
        if (branch_taken) begin
          next_pc = pc_target;
        end
      end
      opc_system: begin
        rd_data_pre = csr_rdata;
        if (ctrl.csr_op == csr_ecall) begin
          next_pc = mtvec;
        end else if (ctrl.csr_op == csr_mret) begin
          next_pc = mepc;
        end
      end
      default: begin
      end
    endcase
    if (ctrl.illegal) begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= ctrl.valid;
    end
  end

  always_ff @(posedge clk) begin
    res.alu_result   <= alu_result;
    res.store_data   <= ctrl.rs2_data;
    res.mem_read     <= ctrl.mem_read;
    res.mem_write    <= ctrl.mem_write;
    res.mem_size     <= ctrl.mem_size;
    res.mem_unsigned <= ctrl.mem_unsigned;
    res.rd           <= ctrl.rd;
    res.rd_we        <= ctrl.rd_we;
    res.rd_data_pre  <= rd_data_pre;
    res.next_pc      <= next_pc;
    res.ebreak       <= ctrl.csr_op == csr_ebreak;
    res.illegal      <= ctrl.illegal;
  end

endmodule

// File: source/load_store_result.sv
`timescale 1ns/1ps

module load_store_result (
  input  logic                     clk,
  input  logic                     rst,
  exu_result_if.sink               res,
  output logic                     out_valid_o,
  output logic                     rd_we_o,
  output logic [4:0]               rd_addr_o,
  output logic [exu_pkg::xlen-1:0] rd_data_o,
  output logic [exu_pkg::xlen-1:0] next_pc_o,
  output logic                     trap_o,
  output logic                     illegal_o
);
  import exu_pkg::*;

  logic [xlen-1:0]    mem [dmem_words] = '{default: '0};
  logic [dmem_aw-1:0] word_idx;
  logic [1:0]         lane;
  logic [3:0]         byte_en;
  logic [xlen-1:0]    store_word;
  logic [xlen-1:0]    rdata_q;
  logic [xlen-1:0]    pre_q;
  logic               load_q;
  logic               unsigned_q;
  logic [1:0]         size_q;
  logic [1:0]         lane_q;
  logic [7:0]         load_byte;
  logic [15:0]        load_half;
  logic [xlen-1:0]    load_data;

  assign word_idx = res.alu_result[dmem_aw+1:2];
  assign lane     = res.alu_result[1:0];

  // misaligned halves and words fall back to the aligned word
  always_comb begin
    case (res.mem_size)
      size_byte: begin
        byte_en    = 4'b0001 << lane;
        store_word = {4{res.store_data[7:0]}};
      end
      size_half: begin
        byte_en    = 4'b0011 << {lane[1], 1'b0};
        store_word = {2{res.store_data[15:0]}};
      end
      size_word: begin
        byte_en    = 4'b1111;
        store_word = res.store_data;
      end
      default: begin
        byte_en    = 4'b0000;
        store_word = res.store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (res.valid && res.mem_write) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= store_word[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
      rd_we_o     <= 1'b0;
      trap_o      <= 1'b0;
      illegal_o   <= 1'b0;
    end else begin
      out_valid_o <= res.valid;
      // x0 is never written
      rd_we_o     <= res.valid && res.rd_we && res.rd != 5'd0;
      trap_o      <= res.valid && res.ebreak;
      illegal_o   <= res.valid && res.illegal;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q    <= mem[word_idx];
    pre_q      <= res.rd_data_pre;
    load_q     <= res.mem_read;
    size_q     <= res.mem_size;
    unsigned_q <= res.mem_unsigned;
    lane_q     <= lane;
    rd_addr_o  <= res.rd;
    next_pc_o  <= res.next_pc;
  end

  assign load_byte = rdata_q[8*lane_q +: 8];
  assign load_half = rdata_q[16*lane_q[1] +: 16];

  always_comb begin
    case (size_q)
      size_byte: load_data = {{(xlen-8){load_byte[7] & ~unsigned_q}}, load_byte};
      size_half: load_data = {{(xlen-16){load_half[15] & ~unsigned_q}}, load_half};
      default:   load_data = rdata_q;
    endcase
  end

  assign rd_data_o = load_q ? load_data : pre_q;

endmodule

// File: source/exu_top.sv
`timescale 1ns/1ps

module exu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid_i,
  input  logic [31:0]              inst_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  input  logic [exu_pkg::xlen-1:0] rs1_data_i,
  input  logic [exu_pkg::xlen-1:0] rs2_data_i,
  output logic                     out_valid_o,
  output logic                     rd_we_o,
  output logic [4:0]               rd_addr_o,
  output logic [exu_pkg::xlen-1:0] rd_data_o,
  output logic [exu_pkg::xlen-1:0] next_pc_o,
  output logic                     trap_o,
  output logic                     illegal_o
);

  exu_ctrl_if   ctrl_if ();
  exu_result_if res_if ();

  inst_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .ctrl       (ctrl_if.source)
  );

  execute_unit u_execute (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl_if.sink),
    .res  (res_if.source)
  );

  load_store_result u_result (
    .clk         (clk),
    .rst         (rst),
    .res         (res_if.sink),
    .out_valid_o (out_valid_o),
    .rd_we_o     (rd_we_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_o   (rd_data_o),
    .next_pc_o   (next_pc_o),
    .trap_o      (trap_o),
    .illegal_o   (illegal_o)
  );

endmodule

// File: tests/exu_ref_model.svh
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

typedef struct {
  logic [4:0]      rd;
  logic            rd_we;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] next_pc;
  logic            trap;
  logic            illegal;
  int              edge_no;
} expect_t;

logic [xlen-1:0] model_mem [dmem_words];
logic [xlen-1:0] model_mstatus;
logic [xlen-1:0] model_mtvec;
logic [xlen-1:0] model_mepc;
logic [xlen-1:0] model_mcause;

function automatic void clear_model();
  model_mem     = '{default: '0};
  model_mstatus = '0;
  model_mtvec   = '0;
  model_mepc    = '0;
  model_mcause  = '0;
endfunction

function automatic logic [xlen-1:0] csr_value(input logic [11:0] addr);
  case (addr)
    csr_mstatus: return model_mstatus;
    csr_mtvec:   return model_mtvec;
    csr_mepc:    return model_mepc;
    csr_mcause:  return model_mcause;
    default:     return '0;
  endcase
endfunction

function automatic void csr_update(input logic [11:0] addr, input logic [xlen-1:0] val);
  case (addr)
    csr_mstatus: model_mstatus = val;
    csr_mtvec:   model_mtvec   = val;
    csr_mepc:    model_mepc    = val;
    csr_mcause:  model_mcause  = val;
    default: begin
    end
  endcase
endfunction

function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [xlen-1:0] x,
                                            input logic [xlen-1:0] y);
  logic [xlen-1:0] shr;
  if (alt) shr = $signed(x) >>> y[4:0];
  else shr = x >> y[4:0];
  case (f3)
    3'd0:    return alt ? x - y : x + y;
    3'd1:    return x << y[4:0];
    3'd2:    return {31'b0, $signed(x) < $signed(y)};
    3'd3:    return {31'b0, x < y};
    3'd4:    return x ^ y;
    3'd5:    return shr;
    3'd6:    return x | y;
    default: return x & y;
  endcase
endfunction

// word index from address bits 9..2
function automatic logic [xlen-1:0] load_value(input logic [2:0] f3,
                                               input logic [xlen-1:0] addr);
  logic [xlen-1:0] word;
  logic [7:0]      lb;
  logic [15:0]     lh;
  word = model_mem[addr[9:2]];
  lb   = word[8*addr[1:0] +: 8];
  lh   = word[16*addr[1] +: 16];
  case (f3)
    3'd0:    return {{24{lb[7]}}, lb};
    3'd1:    return {{16{lh[15]}}, lh};
    3'd4:    return {24'b0, lb};
    3'd5:    return {16'b0, lh};
    default: return word;
  endcase
endfunction

function automatic void store_value(input logic [2:0] f3, input logic [xlen-1:0] addr,
                                    input logic [xlen-1:0] data);
  case (f3)
    3'd0:    model_mem[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];
    3'd1:    model_mem[addr[9:2]][16*addr[1] +: 16] = data[15:0];
    default: model_mem[addr[9:2]] = data;
  endcase
endfunction

// expected outputs of one instruction, model state updated in program order
function automatic expect_t predict(input logic [31:0] inst, input logic [xlen-1:0] pc,
                                    input logic [xlen-1:0] a, input logic [xlen-1:0] b);
  expect_t         e;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] src;
  logic            taken;
  logic            wr;
  f3        = inst[14:12];
  f7        = inst[31:25];
  imm_i     = {{20{inst[31]}}, inst[31:20]};
  imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  imm_b     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  e.rd      = inst[11:7];
  e.rd_we   = 1'b0;
  e.rd_data = '0;
  e.next_pc = pc + 4;
  e.trap    = 1'b0;
  e.illegal = 1'b0;
  e.edge_no = 0;
  wr        = 1'b0;
  case (inst[6:0])
    opc_lui: begin
      wr        = 1'b1;
      e.rd_data = {inst[31:12], 12'b0};
    end
    opc_auipc: begin
      wr        = 1'b1;
      e.rd_data = pc + {inst[31:12], 12'b0};
    end
    opc_jal: begin
      wr        = 1'b1;
      e.rd_data = pc + 4;
      e.next_pc = pc + imm_j;
    end
    opc_jalr: begin
      e.illegal = f3 != 3'd0;
      wr        = 1'b1;
      e.rd_data = pc + 4;
      if (!e.illegal) e.next_pc = (a + imm_i) & ~32'd1;
    end
    opc_branch: begin
      case (f3)
        3'd0: taken = a == b;
        3'd1: taken = a != b;
        3'd4: taken = $signed(a) < $signed(b);
        3'd5: taken = $signed(a) >= $signed(b);
        3'd6: taken = a < b;
        3'd7: taken = a >= b;
        default: begin
          taken     = 1'b0;
          e.illegal = 1'b1;
        end
      endcase
      if (taken) e.next_pc = pc + imm_b;
    end
    opc_load: begin
      e.illegal = f3 == 3'd3 || f3 > 3'd5;
      wr        = 1'b1;
      if (!e.illegal) e.rd_data = load_value(f3, a + imm_i);
    end
    opc_store: begin
      e.illegal = f3 > 3'd2;
      if (!e.illegal) store_value(f3, a + imm_s, b);
    end
    opc_op_imm: begin
      e.illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                  (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      wr        = 1'b1;
      e.rd_data = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
    end
    opc_op: begin
      e.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      wr        = 1'b1;
      e.rd_data = alu_ref(f3, f7 == 7'h20, a, b);
    end
    opc_system: begin
      if (inst == 32'h0000_0073) begin
        // ecall
        e.next_pc    = model_mtvec;
        model_mepc   = pc;
        model_mcause = mcause_ecall_m;
      end else if (inst == 32'h0010_0073) begin
        e.trap = 1'b1;
      end else if (inst == 32'h3020_0073) begin
        // mret
        e.next_pc = model_mepc;
        model_mstatus[mstatus_mie_idx]  = model_mstatus[mstatus_mpie_idx];
        model_mstatus[mstatus_mpie_idx] = 1'b1;
      end else if (f3 == 3'd0 || f3 == 3'd4) begin
        e.illegal = 1'b1;
      end else begin
        src       = f3[2] ? {27'b0, inst[19:15]} : a;
        wr        = 1'b1;
        e.rd_data = csr_value(inst[31:20]);
        case (f3[1:0])
          2'd1:    csr_update(inst[31:20], src);
          2'd2:    csr_update(inst[31:20], e.rd_data | src);
          default: csr_update(inst[31:20], e.rd_data & ~src);
        endcase
      end
    end
    default: e.illegal = 1'b1;
  endcase
  e.rd_we = wr && !e.illegal && e.rd != 5'd0;
  return e;
endfunction

`endif

// File: tests/tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top;
  import exu_pkg::*;

  localparam int num_insts   = 2000;
  localparam int max_cycles  = num_insts * 2 + 100;
  localparam int latency     = 3;
  localparam int half_period = 20;
  localparam int drive_delay = 2;

  logic            clk;
  logic            rst;
  logic            in_valid_i;
  logic [31:0]     inst_i;
  logic [xlen-1:0] pc_i;
  logic [xlen-1:0] rs1_data_i;
  logic [xlen-1:0] rs2_data_i;
  logic            out_valid_o;
  logic            rd_we_o;
  logic [4:0]      rd_addr_o;
  logic [xlen-1:0] rd_data_o;
  logic [xlen-1:0] next_pc_o;
  logic            trap_o;
  logic            illegal_o;

  `include "exu_ref_model.svh"

  integer  seed;
  int      cycle;
  int      issued;
  expect_t exp_q [$];

  exu_top uut (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .out_valid_o (out_valid_o),
    .rd_we_o     (rd_we_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_o   (rd_data_o),
    .next_pc_o   (next_pc_o),
    .trap_o      (trap_o),
    .illegal_o   (illegal_o)
  );

  task automatic stop_on_failure();
    $display("Regression failed");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // weighted instruction mix
  task automatic make_inst(output logic [31:0] inst, output logic [xlen-1:0] a,
                           output logic [xlen-1:0] b);
    int          kind;
    logic [31:0] r;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [11:0] offs;
    logic [11:0] csr;
    kind = {$random(seed)} % 100;
    r    = $random(seed);
    rd   = ({$random(seed)} % 8 == 0) ? 5'd0 : r[11:7];
    a    = $random(seed);
    b    = $random(seed);
    f3   = r[14:12];
    if (kind < 20) begin
      if (f3 == 3'd1) r[31:25] = 7'b0;
      if (f3 == 3'd5) r[31:25] = {1'b0, r[30], 5'b0};
      inst = {r[31:15], f3, rd, opc_op_imm};
    end else if (kind < 35) begin
      inst = {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? r[30] : 1'b0, 5'b0, r[24:15], f3, rd, opc_op};
    end else if (kind < 40) begin
      inst = {r[31:12], rd, r[0] ? opc_lui : opc_auipc};
    end else if (kind < 50) begin
      if (f3[2:1] == 2'b01) f3[1] = 1'b0;
      if (r[4]) b = a;
      inst = {r[31:15], f3, r[11:7], opc_branch};
    end else if (kind < 55) begin
      if (r[0]) inst = {r[31:12], rd, opc_jal};
      else inst = {r[31:15], 3'd0, rd, opc_jalr};
    end else if (kind < 77) begin
      // small aligned window so loads hit earlier stores
      a    = a & 32'h0000_00f0;
      offs = {6'b0, r[25:20]};
      if (kind < 65) begin
        f3 = 3'({$random(seed)} % 3);
      end else begin
        f3 = 3'({$random(seed)} % 5);
        if (f3 > 3'd2) f3 = f3 + 3'd1;
      end
      if (f3[1:0] == 2'd1) offs[0] = 1'b0;
      if (f3[1:0] == 2'd2) offs[1:0] = 2'b0;
      if (kind < 65) inst = {offs[11:5], r[24:15], f3, offs[4:0], opc_store};
      else inst = {offs, r[19:15], f3, rd, opc_load};
    end else if (kind < 89) begin
      f3 = 3'({$random(seed)} % 6);
      f3 = f3 + ((f3 > 3'd2) ? 3'd2 : 3'd1);
      case (r[2:0])
        3'd0, 3'd1: csr = csr_mstatus;
        3'd2:       csr = csr_mtvec;
        3'd3, 3'd4: csr = csr_mepc;
        3'd5:       csr = csr_mcause;
        3'd6:       csr = 12'h340;
        default:    csr = r[31:20];
      endcase
      inst = {csr, r[19:15], f3, rd, opc_system};
    end else if (kind < 94) begin
      case (r[1:0])
        2'd0:    inst = 32'h0000_0073;
        2'd1:    inst = 32'h0010_0073;
        default: inst = 32'h3020_0073;
      endcase
    end else begin
      // undefined encodings
      case (r[2:0])
        3'd0:    inst = {r[31:7], 7'b1111111};
        3'd1:    inst = {7'b0000001, r[24:15], f3, rd, opc_op};
        3'd2:    inst = {r[31:15], 3'd3, rd, opc_load};
        3'd3:    inst = {r[31:15], 3'd4, rd, opc_system};
        3'd4:    inst = {r[31:15], 3'd2, r[11:7], opc_branch};
        3'd5:    inst = {r[31:15], 3'd3, r[11:7], opc_store};
        3'd6:    inst = {12'h105, 13'h0, opc_system};
        default: inst = {r[31:15], 3'd1, rd, opc_jalr};
      endcase
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // cycle count and timeout
  initial begin
    cycle = 0;
    while (cycle < max_cycles) begin
      @(posedge clk);
      cycle++;
    end
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    stop_on_failure();
  end

  initial begin
    expect_t         e;
    logic [31:0]     inst;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] pc;
    seed       = 32'h2668c51c;
    issued     = 0;
    rst        = 1'b1;
    in_valid_i = 1'b0;
    inst_i     = '0;
    pc_i       = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    clear_model();
    repeat (16) @(posedge clk);
    #drive_delay;
    compare_value("out_valid_o", out_valid_o, 1'b0);
    compare_value("rd_we_o", rd_we_o, 1'b0);
    compare_value("trap_o", trap_o, 1'b0);
    compare_value("illegal_o", illegal_o, 1'b0);
    rst = 1'b0;
    while (issued < num_insts) begin
      @(posedge clk);
      #drive_delay;
      if ({$random(seed)} % 4 == 0) begin
        in_valid_i = 1'b0;
        inst_i     = $random(seed);
      end else begin
        make_inst(inst, a, b);
        pc        = $random(seed) & 32'hffff_fffc;
        e         = predict(inst, pc, a, b);
        // strobe rises just after this edge
        e.edge_no = cycle;
        exp_q.push_back(e);
        in_valid_i = 1'b1;
        inst_i     = inst;
        pc_i       = pc;
        rs1_data_i = a;
        rs2_data_i = b;
        issued++;
      end
    end
    @(posedge clk);
    #drive_delay;
    in_valid_i = 1'b0;
    repeat (latency + 4) @(posedge clk);
    @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared at the output", exp_q.size());
      stop_on_failure();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  // outputs checked mid-cycle
  initial begin
    expect_t e;
    forever begin
      @(negedge clk);
      if (out_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Output valid at cycle %0d with no instruction outstanding", cycle);
          stop_on_failure();
        end else begin
          e = exp_q.pop_front();
          compare_value("latency", cycle - e.edge_no, latency);
          compare_value("rd_we_o", rd_we_o, e.rd_we);
          if (e.rd_we) begin
            compare_value("rd_addr_o", rd_addr_o, e.rd);
            compare_value("rd_data_o", rd_data_o, e.rd_data);
          end
          compare_value("next_pc_o", next_pc_o, e.next_pc);
          compare_value("trap_o", trap_o, e.trap);
          compare_value("illegal_o", illegal_o, e.illegal);
        end
      end else if (exp_q.size() != 0 && cycle - exp_q[0].edge_no >= latency) begin
        $display("No result for the instruction sampled at cycle %0d", exp_q[0].edge_no);
        stop_on_failure();
      end
    end
  end

endmodule

// File: all.f
+incdir+tests
source/exu_pkg.sv
source/exu_ctrl_if.sv
source/exu_result_if.sv
source/inst_decode.sv
source/alu.sv
source/csr_file.sv
source/execute_unit.sv
source/load_store_result.sv
source/exu_top.sv
tests/tb_exu_top.sv
